// File: Makefile
# Verilator build and run of the host testbench.
VERILATOR ?= verilator
TOP       ?= tb_ros2_host
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
TIMESCALE ?= 1ns/1ps
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the testbench, fails unless it passes"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR TIMESCALE VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --timescale $(TIMESCALE) --top-module $(TOP) \
		--Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$($(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qF '** PASS **'

clean:
	rm -rf $(OBJ_DIR)

// File: bench/tb_cases.svh
`ifndef TB_CASES_SVH
`define TB_CASES_SVH

typedef enum logic [3:0] {
    op_reset, op_tx_wait, op_tx_rel, op_cpu_req, op_both_req, op_cpu_wait, op_rx_trip,
    op_len_wr, op_wr_addr, op_wr_nowe, op_len_rnd, op_tbl_rd, op_tbl_rnd
} op_e;

typedef struct packed {
    op_e         op;
    logic [31:0] operand;
    logic [31:0] expected;  // Worked out at run time for the random rows.
} case_t;

localparam int N_CASES = 28;

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Reset grants are {app_engine, app_cpu, rxbuf_engine, rxbuf_cpu, txbuf_engine, txbuf_cpu}.
// LEDs are {led_r, led_g, led_b}; the receive trip is a six cycle trace of rxbuf_cpu.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
localparam case_t CASES [N_CASES] = '{
    '{op_reset, 0, 32'h09},
    '{op_tx_wait, 34, 1}, '{op_tx_rel, 0, 1}, '{op_tx_wait, 33, 1},
    '{op_cpu_req, 0, 1}, '{op_both_req, 0, 32'h2}, '{op_cpu_wait, 3, 2},
    '{op_rx_trip, 0, 32'h30},
    '{op_len_wr, 21, 32'h1}, '{op_len_wr, 0, 32'h0}, '{op_len_wr, 1, 32'h4}, '{op_len_wr, 10, 32'h4},
    '{op_len_wr, 11, 32'h2}, '{op_len_wr, 20, 32'h2}, '{op_len_wr, 65535, 32'h1},
    '{op_wr_addr, 2, 32'h1}, '{op_wr_nowe, 5, 32'h1},
    '{op_len_rnd, 5, 0}, '{op_len_rnd, 5, 0}, '{op_len_rnd, 16, 0},
    '{op_tbl_rd, 0, 32'h0a01a8c0}, '{op_tbl_rd, 1, 32'h045704d2}, '{op_tbl_rd, 2, 32'h00000007},
    '{op_tbl_rd, 3, 32'h626f6f66}, '{op_tbl_rd, 4, 32'h000a7261}, '{op_tbl_rd, 5, 0},
    '{op_tbl_rnd, 3, 0}, '{op_tbl_rnd, 6, 0}
};

// Outgoing message words, addresses 0 to 4.
localparam logic [31:0] MSG_REF [5] = '{
    32'h0a01a8c0, 32'h045704d2, 32'h00000007, 32'h626f6f66, 32'h000a7261
};

logic [31:0] lfsr;

function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < n; i++) begin
        val  = {val[30:0], lfsr[0]};
        lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);  // Galois step.
    end
    return val;
endfunction

`endif

// File: bench/tb_ros2_host.sv
module tb_ros2_host;
    timeunit 1ns;
    timeprecision 1ps;
    import ros2_host_pkg::*;

    `include "tb_cases.svh"

    logic                clk;
    logic                rst_n;
    engine_ctl_t         engine_ctl;
    rxbuf_wr_t           rxbuf_wr;
    logic [TXBUF_AW-1:0] txbuf_addr;
    logic                cpu_app_req;
    logic                cpu_app_rel;
    grant_t              grants;
    logic [WORD_W-1:0]   txbuf_rdata;
    logic                led_r;
    logic                led_g;
    logic                led_b;
    logic [31:0]         led_word;
    int                  cycle_cnt;
    int                  tx_mark;
    int                  err_cnt;
    int                  pass_cnt;
    int                  fail_cnt;

    assign led_word = {29'd0, led_r, led_g, led_b};

    ros2_host_top #(
        .TX_PERIOD_LOG2 (5)
    ) dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .engine_ctl  (engine_ctl),
        .rxbuf_wr    (rxbuf_wr),
        .txbuf_addr  (txbuf_addr),
        .grants      (grants),
        .txbuf_rdata (txbuf_rdata),
        .cpu_app_req (cpu_app_req),
        .cpu_app_rel (cpu_app_rel),
        .led_r       (led_r),
        .led_g       (led_g),
        .led_b       (led_b)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic int budget(input case_t c);
        case (c.op)
            op_tx_wait:  return c.operand + 2;
            op_cpu_wait: return c.operand + 8;
            default:     return 8;
        endcase
    endfunction

    // Watchdog.
    initial begin
        int limit;
        limit = 16;
        for (int i = 0; i < N_CASES; i++) begin
            limit += budget(CASES[i]);
        end
        limit = 2 * limit + 200;
        cycle_cnt = 0;
        while (cycle_cnt < limit) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("Timeout after %0d cycles, the test table did not finish", cycle_cnt);
        $display("** FAIL **");
        $finish;
    end

    // Length ranges, red then green then blue.
    function automatic logic [2:0] led_ref(input logic [15:0] len);
        if (len == 16'd0) return 3'b000;
        if (len <= 16'(LED_R_MAX)) return 3'b100;
        if (len <= 16'(LED_G_MAX)) return 3'b010;
        return 3'b001;
    endfunction

    task automatic check_value(input string sig, input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp) else begin
            $display("FAIL t=%0t %s expected %h got %h", $time, sig, exp, act);
            err_cnt++;
        end
    endtask

    task automatic tick();
        @(posedge clk);
        #5;  // Drive and sample slot.
        assert (!(grants.app_engine && grants.app_cpu)) else begin
            $display("Both application grants were high at t=%0t", $time);
            err_cnt++;
        end
    endtask

    task automatic rx_write(input logic [RXBUF_AW-1:0] addr, input logic we,
                            input logic [15:0] len);
        rxbuf_wr.addr  = addr;
        rxbuf_wr.ce    = 1'b1;
        rxbuf_wr.we    = we;
        rxbuf_wr.wdata = {len, 16'h5a5a};
        tick();
        rxbuf_wr = '0;
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // One table row.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic run_case(input case_t c);
        int          n;
        logic [31:0] val;
        n = 0;
        case (c.op)
            op_reset: begin
                check_value("grants", c.expected, {26'd0, grants});
                check_value("txbuf_rdata", 0, txbuf_rdata);
                check_value("leds", 0, led_word);
            end
            op_tx_wait: begin
                while (!grants.txbuf_engine && (cycle_cnt - tx_mark) < c.operand) begin
                    tick();
                end
                assert (grants.txbuf_engine) else begin
                    $display("txbuf_engine did not rise within %0d cycles", c.operand);
                    err_cnt++;
                end
                tx_mark = cycle_cnt;
            end
            op_tx_rel: begin
                engine_ctl.txbuf_rel = 1'b1;
                tick();
                engine_ctl.txbuf_rel = 1'b0;
                check_value("txbuf_cpu", c.expected, 32'(grants.txbuf_cpu));
            end
            op_cpu_req: begin
                cpu_app_req = 1'b1;
                while (!grants.app_cpu && n < 8) begin
                    tick();
                    n++;
                end
                cpu_app_req = 1'b0;
                check_value("app_cpu latency", c.expected, n);
                cpu_app_rel = 1'b1;
                tick();
                cpu_app_rel = 1'b0;
            end
            op_both_req: begin
                engine_ctl.app_req = 1'b1;
                cpu_app_req        = 1'b1;
                tick();
                engine_ctl.app_req = 1'b0;
                cpu_app_req        = 1'b0;
                check_value("app grants", c.expected, 32'({grants.app_engine, grants.app_cpu}));
                engine_ctl.app_rel = 1'b1;
                tick();
                engine_ctl.app_rel = 1'b0;
            end
            op_cpu_wait: begin
                engine_ctl.app_req = 1'b1;
                tick();
                engine_ctl.app_req = 1'b0;
                cpu_app_req        = 1'b1;  // Waits behind the engine.
                repeat (c.operand) tick();
                check_value("app_cpu", 0, 32'(grants.app_cpu));
                engine_ctl.app_rel = 1'b1;
                tick();
                engine_ctl.app_rel = 1'b0;
                n = 1;
                while (!grants.app_cpu && n < 8) begin
                    tick();
                    n++;
                end
                cpu_app_req = 1'b0;
                check_value("app_cpu latency after rel", c.expected, n);
                cpu_app_rel = 1'b1;
                tick();
                cpu_app_rel = 1'b0;
            end
            op_rx_trip: begin
                engine_ctl.rxbuf_rel = 1'b1;
                tick();
                engine_ctl.rxbuf_rel = 1'b0;
                val = '0;
                repeat (6) begin
                    val = {val[30:0], grants.rxbuf_cpu};
                    tick();
                end
                check_value("rxbuf_cpu trace", c.expected, val);
                check_value("rxbuf_engine", 1, 32'(grants.rxbuf_engine));
            end
            op_len_wr, op_len_rnd: begin
                val = c.operand;
                if (c.op == op_len_rnd) begin
                    val        = rand_bits(c.operand);
                    c.expected = 32'(led_ref(val[15:0]));
                end
                rx_write(RXBUF_AW'(RX_LEN_ADDR), 1'b1, val[15:0]);
                check_value("leds", c.expected, led_word);
            end
            op_wr_addr: begin
                rx_write(RXBUF_AW'(c.operand), 1'b1, 16'd5);
                check_value("leds", c.expected, led_word);
            end
            op_wr_nowe: begin
                rx_write(RXBUF_AW'(RX_LEN_ADDR), 1'b0, c.operand[15:0]);
                check_value("leds", c.expected, led_word);
            end
            op_tbl_rd, op_tbl_rnd: begin
                val = c.operand;
                if (c.op == op_tbl_rnd) begin
                    val        = rand_bits(c.operand);
                    c.expected = 0;
                    if (val < 5) c.expected = MSG_REF[val];
                end
                txbuf_addr = val[TXBUF_AW-1:0];
                tick();
                check_value("txbuf_rdata", c.expected, txbuf_rdata);
            end
            default: begin
                $display("Table row holds an unknown operation");
                err_cnt++;
            end
        endcase
    endtask

    initial begin
        int    errs_before;
        case_t c;
        lfsr        = 32'h1a42;
        err_cnt     = 0;
        pass_cnt    = 0;
        fail_cnt    = 0;
        rst_n       = 1'b0;
        engine_ctl  = '0;
        rxbuf_wr    = '0;
        txbuf_addr  = '0;
        cpu_app_req = 1'b0;
        cpu_app_rel = 1'b0;
        repeat (16) tick();
        rst_n   = 1'b1;
        tx_mark = cycle_cnt;  // Timer counts from here.
        for (int i = 0; i < N_CASES; i++) begin
            c           = CASES[i];
            errs_before = err_cnt;
            run_case(c);
            if (err_cnt == errs_before) begin
                pass_cnt++;
                $display("test %0d %s ok", i, c.op.name());
            end else begin
                fail_cnt++;
                $display("test %0d %s failed", i, c.op.name());
            end
        end
        $display("%0d tests passed, %0d tests failed", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// File: hdl/buf_owner_ctrl.sv
module buf_owner_ctrl (
    input  logic                       clk,
    input  logic                       rst_n,
    input  ros2_host_pkg::engine_ctl_t engine_ctl,
    input  logic                       cpu_app_req,
    input  logic                       cpu_app_rel,
    input  logic                       tx_cpu_rel,
    input  logic                       rx_cpu_rel,
    output ros2_host_pkg::grant_t      grants
);
    import ros2_host_pkg::*;

    app_grant_e app_state;
    buf_owner_e rxbuf_owner;
    buf_owner_e txbuf_owner;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Application data arbiter.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            app_state <= grant_none;
        end else begin
            case (app_state)
                grant_none: begin
                    if (engine_ctl.app_req) begin
                        app_state <= grant_engine;  // Engine wins a tie.
                    end else if (cpu_app_req) begin
                        app_state <= grant_cpu;
                    end
                end
                grant_engine: begin
                    if (engine_ctl.app_rel) begin
                        app_state <= grant_none;
                    end
                end
                grant_cpu: begin
                    if (cpu_app_rel) begin
                        app_state <= grant_none;
                    end
                end
                default: app_state <= grant_none;
            endcase
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Buffer ownership switches.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Only the current owner's release is heard.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rxbuf_owner <= owner_engine;
        end else begin
            case (rxbuf_owner)
                owner_engine: begin
                    if (engine_ctl.rxbuf_rel) begin
                        rxbuf_owner <= owner_cpu;
                    end
                end
                default: begin
                    if (rx_cpu_rel) begin
                        rxbuf_owner <= owner_engine;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            txbuf_owner <= owner_cpu;  // CPU fills the first message.
        end else begin
            case (txbuf_owner)
                owner_cpu: begin
                    if (tx_cpu_rel) begin
                        txbuf_owner <= owner_engine;
                    end
                end
                default: begin
                    if (engine_ctl.txbuf_rel) begin
                        txbuf_owner <= owner_cpu;
                    end
                end
            endcase
        end
    end

    always_comb begin
        grants.app_engine   = (app_state == grant_engine);
        grants.app_cpu      = (app_state == grant_cpu);
        grants.rxbuf_engine = (rxbuf_owner == owner_engine);
        grants.rxbuf_cpu    = (rxbuf_owner == owner_cpu);
        grants.txbuf_engine = (txbuf_owner == owner_engine);
        grants.txbuf_cpu    = (txbuf_owner == owner_cpu);
    end

    a_app_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        !(grants.app_engine && grants.app_cpu));

    a_buf_one_owner: assert property (@(posedge clk) disable iff (!rst_n)
        (grants.rxbuf_engine ^ grants.rxbuf_cpu) && (grants.txbuf_engine ^ grants.txbuf_cpu));

endmodule

// File: hdl/host_rx_agent.sv
module host_rx_agent (
    input  logic                     clk,
    input  logic                     rst_n,
    input  ros2_host_pkg::rxbuf_wr_t rxbuf_wr,
    input  logic                     rxbuf_cpu_grant,
    output logic                     rx_cpu_rel,
    output logic                     led_r,
    output logic                     led_g,
    output logic                     led_b
);
    import ros2_host_pkg::*;

    localparam int LEN_W = 16;

    logic [LEN_W-1:0] last_len;
    logic             len_wr;

    assign len_wr = rxbuf_wr.ce && rxbuf_wr.we && (rxbuf_wr.addr == RXBUF_AW'(RX_LEN_ADDR));

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Release and length capture.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rx_cpu_rel <= 1'b0;
            last_len   <= '0;
        end else begin
            rx_cpu_rel <= rxbuf_cpu_grant;  // Nothing to read, give it straight back.
            if (len_wr) begin
                last_len <= rxbuf_wr.wdata[WORD_W-1 -: LEN_W];
            end
        end
    end

    // Length ranges.
    assign led_r = (last_len != '0) && (last_len <= LEN_W'(LED_R_MAX));
    assign led_g = (last_len > LEN_W'(LED_R_MAX)) && (last_len <= LEN_W'(LED_G_MAX));
    assign led_b = (last_len > LEN_W'(LED_G_MAX));

    // The engine may only write while it owns the buffer.
    a_no_write_cpu: assert property (@(posedge clk) disable iff (!rst_n)
        rxbuf_cpu_grant |-> !rxbuf_wr.we);

endmodule

// File: hdl/host_tx_agent.sv
module host_tx_agent #(
    parameter int TX_PERIOD_LOG2 = 27
) (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic [ros2_host_pkg::TXBUF_AW-1:0] txbuf_addr,
    output logic [ros2_host_pkg::WORD_W-1:0]   txbuf_rdata,
    output logic                               tx_cpu_rel
);
    import ros2_host_pkg::*;

    logic [TX_PERIOD_LOG2:0] tx_cnt;
    logic [WORD_W-1:0]       table_word;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Release timer.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tx_cnt     <= '0;
            tx_cpu_rel <= 1'b0;
        end else if (tx_cnt[TX_PERIOD_LOG2]) begin
            tx_cnt     <= '0;
            tx_cpu_rel <= 1'b1;  // Hand the buffer to the engine.
        end else begin
            tx_cnt     <= tx_cnt + 1'b1;
            tx_cpu_rel <= 1'b0;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Outgoing message table.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        case (txbuf_addr)
            TXBUF_AW'(0): table_word = 32'h0a01a8c0;  // Destination IP.
            TXBUF_AW'(1): table_word = 32'h045704d2;  // Ports.
            TXBUF_AW'(2): table_word = 32'h00000007;  // Payload length.
            TXBUF_AW'(3): table_word = 32'h626f6f66;
            TXBUF_AW'(4): table_word = 32'h000a7261;
            default:      table_word = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            txbuf_rdata <= '0;
        end else begin
            txbuf_rdata <= table_word;
        end
    end

    a_rel_single: assert property (@(posedge clk) disable iff (!rst_n)
        tx_cpu_rel |=> !tx_cpu_rel);

endmodule

// File: hdl/ros2_host_pkg.sv
package ros2_host_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Buffer geometry.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int RXBUF_AW    = 10;
    localparam int TXBUF_AW    = 6;
    localparam int WORD_W      = 32;
    localparam int RX_LEN_ADDR = 1;   // Word holding the received length.

    // LED range limits, inclusive upper bounds.
    localparam int LED_R_MAX = 10;
    localparam int LED_G_MAX = 20;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Ownership states.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef enum logic [1:0] {
        grant_none,
        grant_engine,
        grant_cpu
    } app_grant_e;

    typedef enum logic {
        owner_engine,
        owner_cpu
    } buf_owner_e;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Bundles.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef struct packed {
        logic app_req;
        logic app_rel;
        logic rxbuf_rel;
        logic txbuf_rel;
    } engine_ctl_t;

    typedef struct packed {
        logic app_engine;
        logic app_cpu;
        logic rxbuf_engine;
        logic rxbuf_cpu;
        logic txbuf_engine;
        logic txbuf_cpu;
    } grant_t;

    typedef struct packed {
        logic [RXBUF_AW-1:0] addr;
        logic                ce;
        logic                we;
        logic [WORD_W-1:0]   wdata;
    } rxbuf_wr_t;

endpackage

// File: hdl/ros2_host_top.sv
module ros2_host_top #(
    parameter int TX_PERIOD_LOG2 = 27
) (
    input  logic                               clk,
    input  logic                               rst_n,

    // Engine side.
    input  ros2_host_pkg::engine_ctl_t         engine_ctl,
    input  ros2_host_pkg::rxbuf_wr_t           rxbuf_wr,
    input  logic [ros2_host_pkg::TXBUF_AW-1:0] txbuf_addr,
    output ros2_host_pkg::grant_t              grants,
    output logic [ros2_host_pkg::WORD_W-1:0]   txbuf_rdata,

    // External CPU.
    input  logic                               cpu_app_req,
    input  logic                               cpu_app_rel,

    output logic                               led_r,
    output logic                               led_g,
    output logic                               led_b
);

    logic tx_cpu_rel;
    logic rx_cpu_rel;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Ownership control.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    buf_owner_ctrl u_buf_owner_ctrl (
        .clk         (clk),
        .rst_n       (rst_n),
        .engine_ctl  (engine_ctl),
        .cpu_app_req (cpu_app_req),
        .cpu_app_rel (cpu_app_rel),
        .tx_cpu_rel  (tx_cpu_rel),
        .rx_cpu_rel  (rx_cpu_rel),
        .grants      (grants)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Local processor agents.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    host_tx_agent #(
        .TX_PERIOD_LOG2 (TX_PERIOD_LOG2)
    ) u_host_tx_agent (
        .clk         (clk),
        .rst_n       (rst_n),
        .txbuf_addr  (txbuf_addr),
        .txbuf_rdata (txbuf_rdata),
        .tx_cpu_rel  (tx_cpu_rel)
    );

    host_rx_agent u_host_rx_agent (
        .clk             (clk),
        .rst_n           (rst_n),
        .rxbuf_wr        (rxbuf_wr),
        .rxbuf_cpu_grant (grants.rxbuf_cpu),
        .rx_cpu_rel      (rx_cpu_rel),
        .led_r           (led_r),
        .led_g           (led_g),
        .led_b           (led_b)
    );

endmodule

// File: tb.f
hdl/ros2_host_pkg.sv
hdl/buf_owner_ctrl.sv
hdl/host_tx_agent.sv
hdl/host_rx_agent.sv
hdl/ros2_host_top.sv
+incdir+bench
bench/tb_ros2_host.sv
